//--- logic/lin_rw_settings.svh
// linear scan-line sequencer settings: field widths, register map, mode bits, page limits
`ifndef LIN_RW_SETTINGS_SVH
`define LIN_RW_SETTINGS_SVH

`define LIN_ROW_W      15  // ddr3 row address
`define LIN_COL8_W     7   // column in bursts of 8
`define LIN_RC_W       22  // {row, col8}
`define LIN_XFER_W     6   // burst count per transfer, 0 is 64
`define LIN_FW_W       13  // window width in bursts
`define LIN_FH_W       16  // frame height in lines
`define LIN_FNUM_W     16  // frame counter
`define LIN_XPG_W      2   // extra pages field

`define LIN_REG_MODE   4'd0
`define LIN_REG_START  4'd2
`define LIN_REG_SIZE   4'd3
`define LIN_REG_LAST   4'd4
`define LIN_REG_FULLW  4'd5
`define LIN_REG_WH     4'd6
`define LIN_REG_X0Y0   4'd7

`define LIN_MODE_NRST     0   // channel out of reset when set
`define LIN_MODE_EN       1   // request enable
`define LIN_MODE_WR       2   // write to memory
`define LIN_MODE_XPG      3   // extra pages, LIN_XPG_W bits
`define LIN_MODE_RSTF     8   // restart frame ring
`define LIN_MODE_SINGLE   9   // arm one frame
`define LIN_MODE_REPEAT   10  // keep frames armed
`define LIN_MODE_DISNEED  11  // want only, never need

`define LIN_NEED_PAGES 3  // need raised from this page count
`define LIN_RD_PAGES   4  // free pages at frame start in read mode

`endif

//--- logic/lin_rw_pkg.sv
// linear scan-line sequencer types shared between the register, frame, walker and request blocks
`include "lin_rw_settings.svh"

package lin_rw_pkg;

    typedef struct packed {
        logic                  chn_en;         // nrst and en both set
        logic                  chn_rst;        // nrst clear
        logic                  wr_mode;        // 1 memory write, 0 memory read
        logic [`LIN_XPG_W-1:0] extra_pages;    // client holds more than one page
        logic                  repeat_frames;
        logic                  disable_need;
    } lin_mode_t;

    typedef struct packed {
        logic [`LIN_FW_W:0]   full_width;  // line pitch, carry bit set when written as 0
        logic [`LIN_FW_W:0]   width;       // 0 written means max
        logic [`LIN_FH_W:0]   height;      // 0 written means max
        logic [`LIN_FW_W-1:0] x0;
        logic [`LIN_FH_W-1:0] y0;
    } lin_win_t;

    typedef struct packed {
        logic                 frame_go;    // accepted frame start pulse
        logic [`LIN_RC_W-1:0] start_addr;  // frame base {row,col8}
    } lin_frame_t;

    typedef struct packed {
        logic [`LIN_FW_W-1:0] frame_x;     // absolute column in bursts
        logic [`LIN_FH_W-1:0] frame_y;     // absolute line
        logic [`LIN_XFER_W:0] num;         // 1..64
        logic                 last_in_row;
        logic                 last_block;  // last transfer of the window already started
        logic                 pos_valid;
    } lin_pos_t;

    typedef struct packed {
        logic [2:0]             bank;
        logic [`LIN_ROW_W-1:0]  row;
        logic [`LIN_COL8_W-1:0] col;
        logic [`LIN_XFER_W-1:0] num;       // 0 means 64 bursts
    } lin_xfer_t;

endpackage

//--- logic/lin_rw_regs.sv
// command register file: holds window and ring parameters, decodes mode word, makes control pulses
`timescale 1ns/100ps
`include "lin_rw_settings.svh"

module lin_rw_regs (
    input  logic                  mclk,
    input  logic                  mrst,
    input  logic                  cmd_we,
    input  logic [3:0]            cmd_addr,
    input  logic [31:0]           cmd_data,
    output lin_rw_pkg::lin_mode_t mode,
    output lin_rw_pkg::lin_win_t  win,
    output logic [`LIN_RC_W-1:0]  start_range,
    output logic [`LIN_RC_W-1:0]  frame_size,
    output logic [`LIN_FNUM_W-1:0] last_frame,
    output logic                  single_pulse,
    output logic                  rst_frame_pulse,
    output logic                  param_pulse
);
    logic wr_mode;
    logic wr_start;
    logic wr_size;
    logic wr_last;
    logic lsw_zero;
    logic msw_zero;

    assign wr_mode  = cmd_we && (cmd_addr == `LIN_REG_MODE);
    assign wr_start = cmd_we && (cmd_addr == `LIN_REG_START);
    assign wr_size  = cmd_we && (cmd_addr == `LIN_REG_SIZE);
    assign wr_last  = cmd_we && (cmd_addr == `LIN_REG_LAST);
    assign lsw_zero = ~|cmd_data[`LIN_FW_W-1:0];  // carry bit for width 0
    assign msw_zero = ~|cmd_data[31:16];          // carry bit for height 0

    always_ff @(posedge mclk) begin
        if (mrst) begin
            mode            <= '0;
            mode.chn_rst    <= 1'b1;  // channel held in reset until nrst written
            win             <= '0;
            start_range     <= '0;
            frame_size      <= '0;
            last_frame      <= '0;
            single_pulse    <= 1'b0;
            rst_frame_pulse <= 1'b0;
            param_pulse     <= 1'b0;
        end else begin
            single_pulse    <= wr_mode && cmd_data[`LIN_MODE_SINGLE];
            rst_frame_pulse <= (wr_mode && cmd_data[`LIN_MODE_RSTF]) || wr_start || wr_size || wr_last;
            param_pulse     <= cmd_we;  // any write restarts the recalculation
            if (wr_mode) begin
                mode.chn_en        <= cmd_data[`LIN_MODE_NRST] & cmd_data[`LIN_MODE_EN];
                mode.chn_rst       <= ~cmd_data[`LIN_MODE_NRST];
                mode.wr_mode       <= cmd_data[`LIN_MODE_WR];
                mode.extra_pages   <= cmd_data[`LIN_MODE_XPG +: `LIN_XPG_W];
                mode.repeat_frames <= cmd_data[`LIN_MODE_REPEAT];
                mode.disable_need  <= cmd_data[`LIN_MODE_DISNEED];
            end
            if (wr_start) begin
                start_range <= cmd_data[`LIN_RC_W-1:0];
                frame_size  <= `LIN_RC_W'(1);  // ring of one frame by default
            end else if (wr_size) begin
                frame_size  <= cmd_data[`LIN_RC_W-1:0];
            end
            if (wr_last)
                last_frame <= cmd_data[`LIN_FNUM_W-1:0];
            if (cmd_we && (cmd_addr == `LIN_REG_FULLW))
                win.full_width <= {lsw_zero, cmd_data[`LIN_FW_W-1:0]};
            if (cmd_we && (cmd_addr == `LIN_REG_WH)) begin
                win.width  <= {lsw_zero, cmd_data[`LIN_FW_W-1:0]};
                win.height <= {msw_zero, cmd_data[16 +: `LIN_FH_W]};
            end
            if (cmd_we && (cmd_addr == `LIN_REG_X0Y0)) begin
                win.x0 <= cmd_data[`LIN_FW_W-1:0];
                win.y0 <= cmd_data[16 +: `LIN_FH_W];
            end
        end
    end

endmodule

//--- logic/lin_rw_frame_seq.sv
// frame sequencer: arms frames, counts the frame ring and steps the frame start address
`timescale 1ns/100ps
`include "lin_rw_settings.svh"

module lin_rw_frame_seq (
    input  logic                   mclk,
    input  logic                   mrst,
    input  lin_rw_pkg::lin_mode_t  mode,
    input  logic                   frame_start,
    input  logic                   single_pulse,
    input  logic                   rst_frame_pulse,
    input  logic [`LIN_RC_W-1:0]   start_range,
    input  logic [`LIN_RC_W-1:0]   frame_size,
    input  logic [`LIN_FNUM_W-1:0] last_frame,
    output lin_rw_pkg::lin_frame_t frame,
    output logic [`LIN_FNUM_W-1:0] frame_number
);
    logic                   frame_en;    // next frame_start accepted
    logic                   rst_d;       // ring reload one cycle after counter clear
    logic                   is_last;
    logic [`LIN_FNUM_W-1:0] frame_cnt;   // number the next frame gets
    logic [`LIN_RC_W-1:0]   next_start;  // base the next frame gets

    assign is_last = (frame_cnt == last_frame);

    always_ff @(posedge mclk) begin
        if (mrst) begin
            frame_en     <= 1'b0;
            rst_d        <= 1'b0;
            frame_cnt    <= '0;
            frame_number <= '0;
            next_start   <= '0;
            frame        <= '0;
        end else begin
            rst_d          <= rst_frame_pulse;
            frame.frame_go <= frame_start && frame_en;
            if (single_pulse || mode.repeat_frames)
                frame_en <= 1'b1;
            else if (frame_start)
                frame_en <= 1'b0;  // single frame consumed
            if (rst_frame_pulse) begin
                frame_cnt    <= '0;
                frame_number <= '0;
            end else if (frame.frame_go) begin
                frame_cnt    <= is_last ? '0 : frame_cnt + 1'b1;  // wrap after last_frame
                frame_number <= frame_cnt;
            end
            if (rst_d)
                next_start <= start_range;
            else if (frame.frame_go)
                next_start <= is_last ? start_range : next_start + frame_size;
            if (frame.frame_go)
                frame.start_addr <= next_start;
        end
    end

endmodule

//--- logic/lin_rw_scan_walker.sv
// scan walker: steps x/y through the window and sizes each transfer of a window line
`timescale 1ns/100ps
`include "lin_rw_settings.svh"

module lin_rw_scan_walker (
    input  logic                   mclk,
    input  logic                   mrst,
    input  lin_rw_pkg::lin_mode_t  mode,
    input  lin_rw_pkg::lin_win_t   win,
    input  logic                   param_pulse,
    input  lin_rw_pkg::lin_frame_t frame,
    input  logic                   xfer_started,
    input  logic                   busy,
    output lin_rw_pkg::lin_pos_t   pos
);
    logic [`LIN_FW_W-1:0] curr_x;      // relative to window left
    logic [`LIN_FH_W-1:0] curr_y;      // relative to window top
    logic [`LIN_FW_W:0]   row_left;    // bursts left in the line
    logic [`LIN_FW_W-1:0] frame_x;
    logic [`LIN_FH_W-1:0] frame_y;
    logic                 last_row;
    logic                 last_block;
    logic                 vld;
    logic                 kill;        // position about to change
    logic [`LIN_XFER_W:0] num;
    logic                 last_in_row;

    assign kill = frame.frame_go | xfer_started | param_pulse | mode.chn_rst;

    always_ff @(posedge mclk) begin
        if (mrst || mode.chn_rst || frame.frame_go) begin
            curr_x <= '0;  // every frame starts top left
            curr_y <= '0;
        end else if (xfer_started) begin
            if (last_in_row) begin
                curr_x <= '0;
                curr_y <= curr_y + 1'b1;
            end else begin
                curr_x <= curr_x + {{(`LIN_FW_W-`LIN_XFER_W-1){1'b0}}, num};
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (mrst) begin
            vld        <= 1'b0;
            last_block <= 1'b0;
        end else begin
            vld <= ~kill;
            if (mode.chn_rst || !busy || frame.frame_go)
                last_block <= 1'b0;
            else if (xfer_started)
                last_block <= last_row && last_in_row;  // window done once this one starts
        end
    end

    // recalculated every cycle from the current position
    always_ff @(posedge mclk) begin
        row_left <= win.width - {1'b0, curr_x};
        frame_x  <= curr_x + win.x0;
        frame_y  <= curr_y + win.y0;
        last_row <= ({1'b0, curr_y} + 1'b1) == win.height;
    end

    always_comb begin
        if (|row_left[`LIN_FW_W:`LIN_XFER_W])
            num = {1'b1, {`LIN_XFER_W{1'b0}}};  // capped at 64 bursts
        else
            num = row_left[`LIN_XFER_W:0];
        last_in_row     = (row_left == {{(`LIN_FW_W-`LIN_XFER_W){1'b0}}, num});
        pos.frame_x     = frame_x;
        pos.frame_y     = frame_y;
        pos.num         = num;
        pos.last_in_row = last_in_row;
        pos.last_block  = last_block;
        pos.pos_valid   = vld & ~kill;
    end

endmodule

//--- logic/lin_rw_xfer_req.sv
// request stage: address pipeline, page throttling, want/need, start strobes and frame completion
`timescale 1ns/100ps
`include "lin_rw_settings.svh"

module lin_rw_xfer_req (
    input  logic                   mclk,
    input  logic                   mrst,
    input  lin_rw_pkg::lin_mode_t  mode,
    input  lin_rw_pkg::lin_win_t   win,
    input  lin_rw_pkg::lin_frame_t frame,
    input  lin_rw_pkg::lin_pos_t   pos,
    input  logic                   xfer_grant,
    input  logic                   xfer_done,
    input  logic                   next_page,
    output logic                   xfer_want,
    output logic                   xfer_need,
    output logic                   xfer_start_rd,
    output logic                   xfer_start_wr,
    output lin_rw_pkg::lin_xfer_t  xfer,
    output logic                   xfer_started,
    output logic                   busy,
    output logic                   frame_done,
    output logic                   frame_finished
);
    logic [`LIN_FH_W+`LIN_FW_W-3:0] mul_w;     // (y/8) * pitch
    logic [`LIN_RC_W-1:0]   mul_r;
    logic [`LIN_RC_W-1:0]   start_a;
    logic [`LIN_RC_W-1:0]   row_col;
    logic [`LIN_FW_W-1:0]   fx_a;
    logic [2:0]             bank_a;
    logic [2:0]             bank_b;
    logic [`LIN_XFER_W-1:0] num_a;
    logic [`LIN_XFER_W-1:0] num_b;
    logic [1:0]             addr_sr;           // pos_valid through mul and add stages
    logic                   addr_valid;
    logic                   pre_want;
    logic                   want_set;
    logic [2:0]             page_cnt;          // free pages in the client buffer
    logic [1:0]             pending;           // started, not yet done
    logic                   done_d;

    assign mul_w      = pos.frame_y[`LIN_FH_W-1:3] * win.full_width;
    assign addr_valid = addr_sr[1] & pos.pos_valid;
    assign pre_want   = mode.chn_en & busy & ~xfer_want & ~xfer_started & addr_valid
                        & ~pos.last_block;
    assign want_set   = pre_want && (page_cnt > {1'b0, mode.extra_pages});

    // address pipeline, multiply then add
    always_ff @(posedge mclk) begin
        mul_r   <= mul_w[`LIN_RC_W-1:0];
        start_a <= frame.start_addr;
        fx_a    <= pos.frame_x;
        bank_a  <= pos.frame_y[2:0];  // 8 lines interleave over banks
        num_a   <= pos.num[`LIN_XFER_W-1:0];
        row_col <= start_a + mul_r + {{(`LIN_RC_W-`LIN_FW_W){1'b0}}, fx_a};
        bank_b  <= bank_a;
        num_b   <= num_a;
        if (xfer_grant) begin
            xfer.bank <= bank_b;
            xfer.row  <= row_col[`LIN_RC_W-1:`LIN_COL8_W];
            xfer.col  <= row_col[`LIN_COL8_W-1:0];
            xfer.num  <= num_b;
        end
    end

    always_ff @(posedge mclk) begin
        if (mrst) begin
            addr_sr        <= '0;
            xfer_want      <= 1'b0;
            xfer_need      <= 1'b0;
            xfer_start_rd  <= 1'b0;
            xfer_start_wr  <= 1'b0;
            xfer_started   <= 1'b0;
            page_cnt       <= '0;
            pending        <= '0;
            done_d         <= 1'b0;
            busy           <= 1'b0;
            frame_done     <= 1'b0;
            frame_finished <= 1'b0;
        end else begin
            addr_sr       <= {addr_sr[0], pos.pos_valid};
            done_d        <= xfer_done;
            xfer_started  <= xfer_grant && !mode.chn_rst;
            xfer_start_rd <= xfer_grant && !mode.chn_rst && !mode.wr_mode;
            xfer_start_wr <= xfer_grant && !mode.chn_rst && mode.wr_mode;
            if (mode.chn_rst || xfer_grant)
                xfer_want <= 1'b0;
            else if (want_set)
                xfer_want <= 1'b1;
            if (mode.chn_rst || xfer_grant || mode.disable_need)
                xfer_need <= 1'b0;
            else if ((want_set || xfer_want) && (page_cnt >= `LIN_NEED_PAGES))
                xfer_need <= 1'b1;  // only alongside want
            if (frame.frame_go)
                page_cnt <= mode.wr_mode ? 3'd0 : 3'(`LIN_RD_PAGES);
            else if (xfer_started && !next_page)
                page_cnt <= page_cnt - 1'b1;
            else if (!xfer_started && next_page)
                page_cnt <= page_cnt + 1'b1;
            if (mode.chn_rst || !busy)
                pending <= '0;
            else if (xfer_started && !xfer_done)
                pending <= pending + 1'b1;
            else if (!xfer_started && xfer_done)
                pending <= pending - 1'b1;
            if (mode.chn_rst)
                busy <= 1'b0;
            else if (frame.frame_go)
                busy <= 1'b1;
            else if (frame_done)
                busy <= 1'b0;
            frame_done <= busy && pos.last_block && done_d && (pending == '0);
            if (mode.chn_rst || frame.frame_go)
                frame_finished <= 1'b0;
            else if (frame_done)
                frame_finished <= 1'b1;  // held until the next frame
        end
    end

endmodule

//--- logic/lin_rw_top.sv
// linear scan-line sequencer top: register file, frame sequencer, scan walker and request stage
`timescale 1ns/100ps
`include "lin_rw_settings.svh"

module lin_rw_top (
    input  logic                   mclk,
    input  logic                   mrst,
    input  logic                   cmd_we,
    input  logic [3:0]             cmd_addr,
    input  logic [31:0]            cmd_data,
    input  logic                   frame_start,
    input  logic                   next_page,
    input  logic                   xfer_grant,
    input  logic                   xfer_done,
    output logic                   xfer_want,
    output logic                   xfer_need,
    output logic                   xfer_start_rd,
    output logic                   xfer_start_wr,
    output lin_rw_pkg::lin_xfer_t  xfer,
    output logic [`LIN_FNUM_W-1:0] frame_number,
    output logic                   frame_done,
    output logic                   frame_finished
);
    lin_rw_pkg::lin_mode_t  mode;
    lin_rw_pkg::lin_win_t   win;
    lin_rw_pkg::lin_frame_t frame;
    lin_rw_pkg::lin_pos_t   pos;
    logic [`LIN_RC_W-1:0]   start_range;
    logic [`LIN_RC_W-1:0]   frame_size;
    logic [`LIN_FNUM_W-1:0] last_frame;
    logic                   single_pulse;
    logic                   rst_frame_pulse;
    logic                   param_pulse;
    logic                   xfer_started;
    logic                   busy;

    lin_rw_regs i_regs (
        .mclk(mclk), .mrst(mrst), .cmd_we(cmd_we), .cmd_addr(cmd_addr), .cmd_data(cmd_data),
        .mode(mode), .win(win), .start_range(start_range), .frame_size(frame_size),
        .last_frame(last_frame), .single_pulse(single_pulse),
        .rst_frame_pulse(rst_frame_pulse), .param_pulse(param_pulse)
    );

    lin_rw_frame_seq i_frame_seq (
        .mclk(mclk), .mrst(mrst), .mode(mode), .frame_start(frame_start),
        .single_pulse(single_pulse), .rst_frame_pulse(rst_frame_pulse),
        .start_range(start_range), .frame_size(frame_size), .last_frame(last_frame),
        .frame(frame), .frame_number(frame_number)
    );

    lin_rw_scan_walker i_walker (
        .mclk(mclk), .mrst(mrst), .mode(mode), .win(win), .param_pulse(param_pulse),
        .frame(frame), .xfer_started(xfer_started), .busy(busy), .pos(pos)
    );

    lin_rw_xfer_req i_xfer_req (
        .mclk(mclk), .mrst(mrst), .mode(mode), .win(win), .frame(frame), .pos(pos),
        .xfer_grant(xfer_grant), .xfer_done(xfer_done), .next_page(next_page),
        .xfer_want(xfer_want), .xfer_need(xfer_need), .xfer_start_rd(xfer_start_rd),
        .xfer_start_wr(xfer_start_wr), .xfer(xfer), .xfer_started(xfer_started),
        .busy(busy), .frame_done(frame_done), .frame_finished(frame_finished)
    );

endmodule

//--- tests/lin_rw_checker.sv
// protocol checker for the sequencer top: reset state, grant to start timing, strobe exclusivity
`timescale 1ns/100ps

module lin_rw_checker (
    input logic mclk,
    input logic mrst,
    input logic xfer_grant,
    input logic xfer_want,
    input logic xfer_need,
    input logic xfer_start_rd,
    input logic xfer_start_wr,
    input logic frame_done
);
    // quiet during reset and on the cycle after it
    a_reset_quiet: assert property (@(posedge mclk)
        mrst |=> !xfer_want && !xfer_need && !xfer_start_rd && !xfer_start_wr)
        else $error("request or start active around reset");

    a_grant_start: assert property (@(posedge mclk) disable iff (mrst)
        xfer_grant |=> (xfer_start_rd || xfer_start_wr))
        else $error("no start one cycle after grant");

    a_start_grant: assert property (@(posedge mclk) disable iff (mrst)
        (xfer_start_rd || xfer_start_wr) |-> $past(xfer_grant))
        else $error("start without a grant one cycle before");

    a_one_dir: assert property (@(posedge mclk) disable iff (mrst)
        !(xfer_start_rd && xfer_start_wr))
        else $error("read and write start together");

    a_need_want: assert property (@(posedge mclk) disable iff (mrst)
        xfer_need |-> xfer_want)
        else $error("need without want");

    a_done_pulse: assert property (@(posedge mclk) disable iff (mrst)
        frame_done |=> !frame_done)
        else $error("frame_done longer than one cycle");

endmodule

bind lin_rw_top lin_rw_checker i_checker (.*);

//--- tests/lin_rw_tb.sv
// testbench for the sequencer: arbiter model, descriptor reference model and result assertions
`timescale 1ns/100ps
`include "lin_rw_settings.svh"

module lin_rw_tb;
    logic mclk = 1'b0;
    logic mrst, cmd_we, frame_start, next_page, xfer_grant, xfer_done;
    logic [3:0]  cmd_addr;
    logic [31:0] cmd_data;
    logic xfer_want, xfer_need, xfer_start_rd, xfer_start_wr, frame_done, frame_finished;
    lin_rw_pkg::lin_xfer_t  xfer;
    logic [`LIN_FNUM_W-1:0] frame_number;

    lin_rw_pkg::lin_xfer_t exp_q[$];          // descriptors still to come
    lin_rw_pkg::lin_xfer_t exp_cur;           // descriptor of the start being checked
    int done_q[$];                            // cycles left until each xfer_done
    int seed = 78;
    int errors = 0, pass_cnt = 0, fail_cnt = 0, test_err0 = 0;
    int cycles = 0, cycle_limit = 100000;
    int frame_starts = 0, exp_count = 0, done_count = 0, pages_model = 0;
    int page_credit = 0, withheld = 0, page_limit = 4, grant_wait = 0;
    logic [`LIN_FNUM_W-1:0] exp_fnum = '0;
    logic hold_pages = 0, wr_cfg = 0, dis_need_cfg = 0, grant_armed = 0, done_seen = 0;

    lin_rw_top i_dut (.*);

    always #50 mclk = ~mclk;

    always @(posedge mclk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not complete within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic int lcg();
        seed = seed * 1103515245 + 12345;
        return (seed >>> 16) & 32'h7fff;
    endfunction

    // arbiter and client model, everything on the falling edge
    always @(negedge mclk) begin
        int idx;
        idx = -1;
        if (!mrst) begin
            xfer_grant = 1'b0;
            xfer_done  = 1'b0;
            next_page  = 1'b0;
            if (xfer_start_rd || xfer_start_wr) begin
                frame_starts++;
                pages_model--;
                if (exp_q.size() > 0)
                    exp_cur = exp_q.pop_front();  // compared at the next rising edge
                else begin
                    errors++;
                    $display("start seen with no descriptor left in the reference model");
                end
                done_q.push_back(1 + lcg() % 8);
            end
            if (xfer_want && !grant_armed) begin
                grant_wait  = lcg() % 4;
                grant_armed = 1'b1;
            end
            if (grant_armed) begin
                if (grant_wait == 0) begin
                    xfer_grant  = 1'b1;
                    grant_armed = 1'b0;
                end else
                    grant_wait--;
            end
            foreach (done_q[i]) begin
                done_q[i]--;
                if (done_q[i] <= 0 && idx < 0)
                    idx = i;
            end
            if (idx >= 0) begin
                done_q.delete(idx);  // one done per cycle, others wait
                xfer_done = 1'b1;
                if (hold_pages)
                    withheld++;
                else
                    page_credit++;
            end
            if (page_credit > 0) begin
                next_page = 1'b1;
                page_credit--;
                pages_model++;
            end
            if (frame_done) begin
                done_count++;
                done_seen = 1'b1;
            end
        end
    end

    a_xfer: assert property (@(posedge mclk) disable iff (mrst)
        (xfer_start_rd || xfer_start_wr) |-> xfer == exp_cur)
        else begin
            errors++;
            $display("[ERROR] %0t xfer expected %h actual %h", $time, exp_cur, $sampled(xfer));
        end
    a_fnum: assert property (@(posedge mclk) disable iff (mrst)
        (xfer_start_rd || xfer_start_wr) |-> frame_number == exp_fnum)
        else begin
            errors++;
            $display("[ERROR] %0t frame_number expected %0d actual %0d", $time, exp_fnum,
                     $sampled(frame_number));
        end
    a_count: assert property (@(posedge mclk) disable iff (mrst)
        frame_done |-> frame_starts == exp_count)
        else begin
            errors++;
            $display("[ERROR] %0t transfer count expected %0d actual %0d", $time, exp_count,
                     frame_starts);
        end
    a_dir: assert property (@(posedge mclk) disable iff (mrst)
        (xfer_start_rd || xfer_start_wr) |-> xfer_start_wr == wr_cfg)
        else begin
            errors++;
            $display("[ERROR] %0t xfer_start_wr expected %b actual %b", $time, wr_cfg,
                     $sampled(xfer_start_wr));
        end
    a_throttle: assert property (@(posedge mclk) disable iff (mrst)
        (hold_pages && xfer_want) |-> frame_starts < page_limit)
        else begin
            errors++;
            $display("request raised with no free page left, %0d starts", frame_starts);
        end
    a_need: assert property (@(posedge mclk) disable iff (mrst)
        $rose(xfer_need) |-> (pages_model >= `LIN_NEED_PAGES) && !dis_need_cfg)
        else begin
            errors++;
            $display("need raised with %0d pages or need disabled", pages_model);
        end

    function automatic int xfer_count(input int w, input int h);
        return h * ((w + 63) / 64);
    endfunction

    // reference descriptors for one frame in scan-line order
    task automatic push_frame(input logic [21:0] base, input int fullw, input int w,
                              input int h, input int x0, input int y0);
        int x;
        int n;
        int fy;
        logic [21:0] a;
        lin_rw_pkg::lin_xfer_t d;
        for (int y = 0; y < h; y++) begin
            x = 0;
            while (x < w) begin
                n      = (w - x > 64) ? 64 : w - x;
                fy     = y + y0;
                a      = base + 22'((fy / 8) * fullw) + 22'(x + x0);
                d.bank = 3'(fy % 8);
                d.row  = a[21:7];
                d.col  = a[6:0];
                d.num  = 6'(n);  // 64 wraps to 0
                exp_q.push_back(d);
                x += n;
            end
        end
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        @(negedge mclk);
        cmd_we   = 1'b1;
        cmd_addr = addr;
        cmd_data = data;
        @(negedge mclk);
        cmd_we   = 1'b0;
    endtask

    function automatic logic [31:0] mode_word(input logic wr, input int xpg, input logic rpt,
                                              input logic dn);
        logic [31:0] m;
        m = 32'h0;
        m[`LIN_MODE_NRST]    = 1'b1;
        m[`LIN_MODE_EN]      = 1'b1;
        m[`LIN_MODE_WR]      = wr;
        m[`LIN_MODE_XPG +: 2] = 2'(xpg);
        m[`LIN_MODE_SINGLE]  = ~rpt;
        m[`LIN_MODE_REPEAT]  = rpt;
        m[`LIN_MODE_DISNEED] = dn;
        return m;
    endfunction

    task automatic setup(input int start, input int size, input int last, input int fullw,
                         input int w, input int h, input int x0, input int y0);
        write_reg(`LIN_REG_START, start);
        write_reg(`LIN_REG_SIZE, size);
        write_reg(`LIN_REG_LAST, last);
        write_reg(`LIN_REG_FULLW, fullw);
        write_reg(`LIN_REG_WH, (h << 16) | w);
        write_reg(`LIN_REG_X0Y0, (y0 << 16) | x0);
    endtask

    task automatic start_frame(input int fnum, input logic [21:0] base, input int fullw,
                               input int w, input int h, input int x0, input int y0);
        push_frame(base, fullw, w, h, x0, y0);
        exp_fnum     = fnum;
        exp_count    = xfer_count(w, h);
        frame_starts = 0;
        done_count   = 0;
        done_seen    = 1'b0;
        pages_model  = wr_cfg ? 0 : `LIN_RD_PAGES;
        @(negedge mclk);
        frame_start = 1'b1;
        @(negedge mclk);
        frame_start = 1'b0;
        if (wr_cfg) begin
            repeat (3) @(negedge mclk);
            page_credit += 2;  // client fills two pages for writing
        end
    endtask

    task automatic end_frame();
        while (!done_seen)
            @(negedge mclk);
        repeat (3) @(negedge mclk);
        assert (frame_finished && done_count == 1 && exp_q.size() == 0) else begin
            errors++;
            $display("frame end wrong: finished %b, %0d done pulses, %0d descriptors left",
                     frame_finished, done_count, exp_q.size());
        end
    endtask

    task automatic report(input string name);
        if (errors == test_err0) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: %0d errors", name, errors - test_err0);
        end
        test_err0 = errors;
    endtask

    task automatic throttle(input int xpg);
        page_limit = `LIN_RD_PAGES - xpg;
        write_reg(`LIN_REG_MODE, mode_word(0, xpg, 0, 0));
        hold_pages = 1'b1;
        start_frame(0, 22'h30000, 64, 64, 8, 0, 0);
        repeat (150) @(negedge mclk);
        assert (frame_starts == page_limit) else begin
            errors++;
            $display("[ERROR] %0t starts expected %0d actual %0d", $time, page_limit,
                     frame_starts);
        end
        hold_pages = 1'b0;
        page_credit += withheld;  // pages released late
        withheld = 0;
        end_frame();
    endtask

    initial begin
        mrst = 1'b1;
        cmd_we = 1'b0;
        cmd_addr = '0;
        cmd_data = '0;
        frame_start = 1'b0;
        next_page = 1'b0;
        xfer_grant = 1'b0;
        xfer_done = 1'b0;
        exp_cur = '0;
        cycle_limit = 2 * (xfer_count(10, 5) + xfer_count(150, 3) + 4 * xfer_count(20, 2)
                      + 2 * xfer_count(64, 8) + xfer_count(40, 4)) * 20 + 2000;
        repeat (10) @(negedge mclk);
        mrst = 1'b0;

        setup(22'h1000, 0, 0, 200, 10, 5, 3, 5);
        write_reg(`LIN_REG_MODE, mode_word(0, 0, 0, 0));
        start_frame(0, 22'h1000, 200, 10, 5, 3, 5);
        end_frame();
        report("small window read");

        setup(22'h2000, 0, 0, 300, 150, 3, 0, 0);
        write_reg(`LIN_REG_MODE, mode_word(0, 0, 0, 0));
        start_frame(0, 22'h2000, 300, 150, 3, 0, 0);
        end_frame();
        report("wide window");

        setup(22'h20000, 22'h800, 2, 32, 20, 2, 0, 0);
        write_reg(`LIN_REG_MODE, mode_word(0, 0, 1, 0));
        for (int k = 0; k < 4; k++) begin
            start_frame(k % 3, 22'h20000 + 22'(k % 3) * 22'h800, 32, 20, 2, 0, 0);
            end_frame();
        end
        report("frame ring");

        setup(22'h30000, 0, 0, 64, 64, 8, 0, 0);
        throttle(0);
        throttle(2);
        report("page throttling");

        setup(22'h4000, 0, 0, 100, 40, 4, 2, 1);
        wr_cfg = 1'b1;
        dis_need_cfg = 1'b1;
        write_reg(`LIN_REG_MODE, mode_word(1, 0, 0, 1));
        start_frame(0, 22'h4000, 100, 40, 4, 2, 1);
        while (frame_starts < 2)
            @(negedge mclk);
        write_reg(`LIN_REG_X0Y0, (1 << 16) | 2);  // same value, only restarts the pipeline
        end_frame();
        report("write mode");

        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- flist.f
+incdir+logic
logic/lin_rw_pkg.sv
logic/lin_rw_regs.sv
logic/lin_rw_frame_seq.sv
logic/lin_rw_scan_walker.sv
logic/lin_rw_xfer_req.sv
logic/lin_rw_top.sv
tests/lin_rw_checker.sv
tests/lin_rw_tb.sv

//--- Bender.yml
package:
  name: lin_rw

sources:
  - include_dirs:
      - logic
    files:
      - logic/lin_rw_pkg.sv
      - logic/lin_rw_regs.sv
      - logic/lin_rw_frame_seq.sv
      - logic/lin_rw_scan_walker.sv
      - logic/lin_rw_xfer_req.sv
      - logic/lin_rw_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/lin_rw_checker.sv
      - tests/lin_rw_tb.sv
